//--- source/lpPkg.sv
// Line printer shared definitions

package lpPkg;

   //////////////////////////////////////////////////
   // APB geometry
   //////////////////////////////////////////////////

   // Bus data width
   localparam int dataWidth = 16;

   // Bus address width
   localparam int addrWidth = 4;

   // Register byte addresses
   localparam logic [addrWidth-1:0] addrCsra = 4'd0;
   localparam logic [addrWidth-1:0] addrCsrb = 4'd4;

   //////////////////////////////////////////////////
   // Interrupt vectors
   //////////////////////////////////////////////////

   localparam logic [7:0] vecDone = 8'hB0;
   localparam logic [7:0] vecErr  = 8'hB4;

   //////////////////////////////////////////////////
   // CSRA bit positions
   //////////////////////////////////////////////////

   // Enables, writable and readable
   localparam int bitDoneIe = 0;
   localparam int bitErrIe  = 1;

   // Command bits, always read as zero
   localparam int bitInit   = 2;
   localparam int bitGo     = 3;

   // Status flags
   localparam int bitDone   = 8;
   localparam int bitErr    = 9;
   localparam int bitBusy   = 10;

   // Interrupt controller states
   typedef enum logic [2:0] {
      stateIdle     = 3'd0,
      stateActive   = 3'd1,
      stateVectRead = 3'd2,
      stateWait     = 3'd3,
      stateDone     = 3'd4
   } intrState;

endpackage

//--- source/lpIntr.sv
// Printer interrupt channel controller

`timescale 1ns/1ps

module lpIntr
   import lpPkg::*;
(
   input  logic clk,
   input  logic rst,
   input  logic lpInit,     // Controller initialize
   input  logic lpSetIrq,   // Event strobe
   input  logic lpIe,       // Interrupt enable
   input  logic lpIack,     // Acknowledge for this channel
   input  logic csraRead,   // CSRA read access
   output logic lpInt       // Interrupt request
);

   //////////////////////////////////////////////////
   // State register
   //////////////////////////////////////////////////

   intrState state;

   // Request drops once the acknowledge ends
   // Retrigger only after CSRA has been read
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= stateIdle;
      end
      else if (lpInit)
      begin
         // Init wins over any state
         state <= stateIdle;
      end
      else
      begin
         case (state)
            // Waiting for an enabled event
            stateIdle:
            begin
               if (lpSetIrq && lpIe)
                  state <= stateActive;
            end
            // Request up, waiting for acknowledge
            stateActive:
            begin
               if (lpIack)
                  state <= stateVectRead;
            end
            // Vector being read, hold until iack drops
            stateVectRead:
            begin
               if (!lpIack)
                  state <= stateWait;
            end
            // Waiting for a status read
            stateWait:
            begin
               if (csraRead)
                  state <= stateDone;
            end
            // Status read seen, wait for it to finish
            stateDone:
            begin
               if (!csraRead)
                  state <= stateIdle;
            end
            default:
            begin
               state <= stateIdle;
            end
         endcase
      end
   end

   //////////////////////////////////////////////////
   // Request output
   //////////////////////////////////////////////////

   // High while pending or being acknowledged
   assign lpInt = (state == stateActive) || (state == stateVectRead);

endmodule

//--- source/lpCsr.sv
// Printer control and status registers

`timescale 1ns/1ps

module lpCsr
   import lpPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   // APB slave
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [addrWidth-1:0] paddr,
   input  logic [dataWidth-1:0] pwdata,
   output logic [dataWidth-1:0] prdata,
   output logic                 pready,
   // Printer events
   input  logic                 printerDone,
   input  logic                 printerFault,
   input  logic [3:0]           faultCode,
   // To the interrupt controllers
   output logic                 doneSet,
   output logic                 errSet,
   output logic                 doneIe,
   output logic                 errIe,
   output logic                 lpInit,
   output logic                 csraRead
);

   //////////////////////////////////////////////////
   // Access decode
   //////////////////////////////////////////////////

   logic                 accessCycle;
   logic                 csraWrite;
   logic                 csrbRead;
   logic                 goWrite;
   logic                 doneFlag;
   logic                 errFlag;
   logic                 busyFlag;
   logic [3:0]           faultLatch;
   logic [dataWidth-1:0] csraValue;
   logic [dataWidth-1:0] csrbValue;

   // Second phase of an APB transfer
   assign accessCycle = psel && penable;

   assign csraWrite = accessCycle && pwrite && (paddr == addrCsra);
   assign csraRead  = accessCycle && !pwrite && (paddr == addrCsra);
   assign csrbRead  = accessCycle && !pwrite && (paddr == addrCsrb);

   // Command bits of a CSRA write
   assign goWrite = csraWrite && pwdata[bitGo];
   assign lpInit  = csraWrite && pwdata[bitInit];

   // No wait states
   assign pready = 1'b1;

   // Event strobes go straight to the controllers
   // Flags update on the same edge
   assign doneSet = printerDone;
   assign errSet  = printerFault;

   //////////////////////////////////////////////////
   // Enable bits
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         doneIe <= 1'b0;
         errIe  <= 1'b0;
      end
      else if (csraWrite)
      begin
         doneIe <= pwdata[bitDoneIe];
         errIe  <= pwdata[bitErrIe];
      end
   end

   //////////////////////////////////////////////////
   // Status flags and fault code
   //////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         doneFlag   <= 1'b0;
         errFlag    <= 1'b0;
         busyFlag   <= 1'b0;
         faultLatch <= 4'd0;
      end
      else if (lpInit)
      begin
         // Init clears all status
         doneFlag   <= 1'b0;
         errFlag    <= 1'b0;
         busyFlag   <= 1'b0;
         faultLatch <= 4'd0;
      end
      else
      begin
         // Status read clears the event flags
         if (csraRead)
         begin
            doneFlag <= 1'b0;
            errFlag  <= 1'b0;
         end
         // Start of a print job
         if (goWrite)
            busyFlag <= 1'b1;
         // Events override the read clear
         if (printerDone)
         begin
            doneFlag <= 1'b1;
            busyFlag <= 1'b0;
         end
         if (printerFault)
         begin
            errFlag    <= 1'b1;
            busyFlag   <= 1'b0;
            faultLatch <= faultCode;
         end
      end
   end

   //////////////////////////////////////////////////
   // Read data
   //////////////////////////////////////////////////

   // CSRA image, init and go read as zero
   always_comb
   begin
      csraValue          = '0;
      csraValue[bitDoneIe] = doneIe;
      csraValue[bitErrIe]  = errIe;
      csraValue[bitDone]   = doneFlag;
      csraValue[bitErr]    = errFlag;
      csraValue[bitBusy]   = busyFlag;
   end

   // CSRB holds the last fault code
   assign csrbValue = {{(dataWidth-4){1'b0}}, faultLatch};

   // Zero outside a read access
   always_comb
   begin
      if (csraRead)
         prdata = csraValue;
      else if (csrbRead)
         prdata = csrbValue;
      else
         prdata = '0;
   end

endmodule

//--- source/lpIntArb.sv
// Printer interrupt combiner

`timescale 1ns/1ps

module lpIntArb
   import lpPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  logic       doneInt,    // Completion channel request
   input  logic       errInt,     // Fault channel request
   input  logic       iack,       // Bus acknowledge
   output logic       intReq,
   output logic [7:0] intVector,
   output logic       ackDone,    // Acknowledge to completion channel
   output logic       ackErr      // Acknowledge to fault channel
);

   //////////////////////////////////////////////////
   // Acknowledge edge and grant
   //////////////////////////////////////////////////

   logic iackPrev;
   logic iackRise;
   logic grantErr;
   logic selErr;
   logic winnerErr;

   // First cycle of an acknowledge
   assign iackRise = iack && !iackPrev;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         iackPrev <= 1'b0;
         grantErr <= 1'b0;
      end
      else
      begin
         iackPrev <= iack;
         // Fault has priority at grant time
         if (iackRise)
            grantErr <= errInt;
      end
   end

   // Live choice on the rising cycle, latched after
   assign selErr = iackRise ? errInt : grantErr;

   //////////////////////////////////////////////////
   // Request, vector and acknowledge routing
   //////////////////////////////////////////////////

   // Zero latency merge
   assign intReq = doneInt || errInt;

   // Granted channel during acknowledge
   // Otherwise the current priority winner
   assign winnerErr = iack ? selErr : errInt;

   always_comb
   begin
      if (!intReq)
         intVector = 8'h00;
      else if (winnerErr)
         intVector = vecErr;
      else
         intVector = vecDone;
   end

   // Only the granted channel sees iack
   assign ackErr  = iack && selErr;
   assign ackDone = iack && !selErr;

endmodule

//--- source/lpTop.sv
// Line printer interrupt front end

`timescale 1ns/1ps

module lpTop
   import lpPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   // APB slave
   input  logic                 psel,
   input  logic                 penable,
   input  logic                 pwrite,
   input  logic [addrWidth-1:0] paddr,
   input  logic [dataWidth-1:0] pwdata,
   output logic [dataWidth-1:0] prdata,
   output logic                 pready,
   // Printer side
   input  logic                 printerDone,
   input  logic                 printerFault,
   input  logic [3:0]           faultCode,
   // Interrupt bus
   input  logic                 iack,
   output logic                 intReq,
   output logic [7:0]           intVector
);

   //////////////////////////////////////////////////
   // Internal nets
   //////////////////////////////////////////////////

   logic doneSet;
   logic errSet;
   logic doneIe;
   logic errIe;
   logic lpInit;
   logic csraRead;
   logic doneInt;
   logic errInt;
   logic ackDone;
   logic ackErr;

   // Register block
   lpCsr csr_i (
      .clk          (clk),
      .rst          (rst),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .printerDone  (printerDone),
      .printerFault (printerFault),
      .faultCode    (faultCode),
      .doneSet      (doneSet),
      .errSet       (errSet),
      .doneIe       (doneIe),
      .errIe        (errIe),
      .lpInit       (lpInit),
      .csraRead     (csraRead)
   );

   // Completion channel
   lpIntr doneIntr_i (
      .clk      (clk),
      .rst      (rst),
      .lpInit   (lpInit),
      .lpSetIrq (doneSet),
      .lpIe     (doneIe),
      .lpIack   (ackDone),
      .csraRead (csraRead),
      .lpInt    (doneInt)
   );

   // Fault channel
   lpIntr errIntr_i (
      .clk      (clk),
      .rst      (rst),
      .lpInit   (lpInit),
      .lpSetIrq (errSet),
      .lpIe     (errIe),
      .lpIack   (ackErr),
      .csraRead (csraRead),
      .lpInt    (errInt)
   );

   // Merge to one bus request
   lpIntArb intArb_i (
      .clk       (clk),
      .rst       (rst),
      .doneInt   (doneInt),
      .errInt    (errInt),
      .iack      (iack),
      .intReq    (intReq),
      .intVector (intVector),
      .ackDone   (ackDone),
      .ackErr    (ackErr)
   );

endmodule

//--- tb/lpTb.sv
// Line printer front end testbench

`timescale 1ns/1ps

module lpTb
   import lpPkg::*;
();

   // Limit far above the scripted run of about 150 cycles
   localparam int maxCycles = 2000;

   logic                 clk;
   logic                 rst;
   logic                 psel;
   logic                 penable;
   logic                 pwrite;
   logic [addrWidth-1:0] paddr;
   logic [dataWidth-1:0] pwdata;
   logic [dataWidth-1:0] prdata;
   logic                 pready;
   logic                 printerDone;
   logic                 printerFault;
   logic [3:0]           faultCode;
   logic                 iack;
   logic                 intReq;
   logic [7:0]           intVector;

   int          errorCount = 0;
   int          cycleCount = 0;
   int          seed;
   int          holdLen;
   logic [31:0] randWord;
   logic [3:0]  code;

   lpTop dut_i (
      .clk          (clk),
      .rst          (rst),
      .psel         (psel),
      .penable      (penable),
      .pwrite       (pwrite),
      .paddr        (paddr),
      .pwdata       (pwdata),
      .prdata       (prdata),
      .pready       (pready),
      .printerDone  (printerDone),
      .printerFault (printerFault),
      .faultCode    (faultCode),
      .iack         (iack),
      .intReq       (intReq),
      .intVector    (intVector)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   //////////////////////////////////////////////////
   // Checking helpers
   //////////////////////////////////////////////////

   function automatic void checkValue(input string name, input logic [15:0] expVal,
                                      input logic [15:0] actVal);
      assert (actVal === expVal)
      else
      begin
         errorCount++;
         $display("Mismatch at %0t: %s expected %h actual %h", $time, name, expVal, actVal);
      end
   endfunction

   // Expected CSRA image built from the bit map
   function automatic logic [15:0] csraImage(input logic doneIeV, input logic errIeV,
                                             input logic doneV, input logic errV,
                                             input logic busyV);
      logic [15:0] img;
      img = '0;
      img[bitDoneIe] = doneIeV;
      img[bitErrIe]  = errIeV;
      img[bitDone]   = doneV;
      img[bitErr]    = errV;
      img[bitBusy]   = busyV;
      return img;
   endfunction

   // Bus rules sampled just before each edge
   always @(posedge clk)
   begin
      if (!rst)
      begin
         checkValue("pready", 16'd1, {15'd0, pready});
         // Vector is zero exactly when no request
         if (!intReq)
            checkValue("intVector", 16'h0000, {8'd0, intVector});
         else
            assert ((intVector == vecDone) || (intVector == vecErr))
            else
            begin
               errorCount++;
               $display("Request at %0t carries an unknown vector %h", $time, intVector);
            end
         if (!(psel && penable))
            checkValue("prdata", 16'h0000, prdata);
      end
   end

   // Run limit
   always @(posedge clk)
   begin
      cycleCount++;
      if (cycleCount >= maxCycles)
      begin
         $display("Timeout after %0d cycles, completion channel in %s, fault channel in %s",
                  cycleCount, dut_i.doneIntr_i.state.name(), dut_i.errIntr_i.state.name());
         $display("TESTS FAILED");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Bus tasks
   //////////////////////////////////////////////////

   task automatic apbWrite(input logic [addrWidth-1:0] addr, input logic [15:0] data);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b1;
      paddr   = addr;
      pwdata  = data;
      @(negedge clk);
      penable = 1'b1;
      // Write lands on the edge ending access
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic readCheck(input logic [addrWidth-1:0] addr, input logic [15:0] expVal,
                            input string name);
      @(negedge clk);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = addr;
      @(negedge clk);
      penable = 1'b1;
      // Read data during access
      @(posedge clk);
      checkValue(name, expVal, prdata);
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   // One-cycle printer pulses
   task automatic pulseEvent(input logic doneV, input logic faultV, input logic [3:0] codeV);
      @(negedge clk);
      printerDone  = doneV;
      printerFault = faultV;
      faultCode    = codeV;
      @(negedge clk);
      printerDone  = 1'b0;
      printerFault = 1'b0;
   endtask

   task automatic expectRequest(input logic expReq, input logic [7:0] expVec);
      @(posedge clk);
      checkValue("intReq", {15'd0, expReq}, {15'd0, intReq});
      checkValue("intVector", {8'd0, expVec}, {8'd0, intVector});
   endtask

   // Request and granted vector hold while iack is high
   task automatic acknowledge(input int cycles, input logic [7:0] expVec);
      int i;
      @(negedge clk);
      iack = 1'b1;
      for (i = 0; i < cycles; i++)
      begin
         @(posedge clk);
         checkValue("intReq", 16'd1, {15'd0, intReq});
         checkValue("intVector", {8'd0, expVec}, {8'd0, intVector});
         @(negedge clk);
      end
      iack = 1'b0;
      // Edge that sees iack low
      @(posedge clk);
   endtask

   //////////////////////////////////////////////////
   // Stimulus
   //////////////////////////////////////////////////

   initial
   begin
      seed         = 32'had4c;
      clk          = 1'b0;
      rst          = 1'b1;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = '0;
      pwdata       = '0;
      printerDone  = 1'b0;
      printerFault = 1'b0;
      faultCode    = 4'd0;
      iack         = 1'b0;
      repeat (16) @(negedge clk);
      rst = 1'b0;

      // Reset state
      expectRequest(1'b0, 8'h00);
      readCheck(addrCsra, 16'h0000, "CSRA");
      readCheck(addrCsrb, 16'h0000, "CSRB");

      // Go, completion, acknowledge
      apbWrite(addrCsra, (16'd1 << bitGo) | (16'd1 << bitDoneIe));
      readCheck(addrCsra, csraImage(1'b1, 1'b0, 1'b0, 1'b0, 1'b1), "CSRA");
      pulseEvent(1'b1, 1'b0, 4'd0);
      expectRequest(1'b1, vecDone);
      randWord = $random(seed);
      holdLen  = 1 + randWord[1:0];
      acknowledge(holdLen, vecDone);
      expectRequest(1'b0, 8'h00);
      readCheck(addrCsra, csraImage(1'b1, 1'b0, 1'b1, 1'b0, 1'b0), "CSRA");

      // Flags only with both enables clear
      apbWrite(addrCsra, 16'h0000);
      randWord = $random(seed);
      code     = randWord[3:0];
      pulseEvent(1'b1, 1'b0, 4'd0);
      pulseEvent(1'b0, 1'b1, code);
      expectRequest(1'b0, 8'h00);
      expectRequest(1'b0, 8'h00);
      readCheck(addrCsrb, {12'd0, code}, "CSRB");
      readCheck(addrCsra, csraImage(1'b0, 1'b0, 1'b1, 1'b1, 1'b0), "CSRA");
      readCheck(addrCsra, 16'h0000, "CSRA");

      // Both channels at once with the fault served first
      apbWrite(addrCsra, (16'd1 << bitDoneIe) | (16'd1 << bitErrIe));
      randWord = $random(seed);
      code     = randWord[3:0];
      pulseEvent(1'b1, 1'b1, code);
      expectRequest(1'b1, vecErr);
      randWord = $random(seed);
      holdLen  = 1 + randWord[1:0];
      acknowledge(holdLen, vecErr);
      // Completion still pending
      expectRequest(1'b1, vecDone);
      randWord = $random(seed);
      holdLen  = 1 + randWord[1:0];
      acknowledge(holdLen, vecDone);
      expectRequest(1'b0, 8'h00);
      readCheck(addrCsrb, {12'd0, code}, "CSRB");
      readCheck(addrCsra, csraImage(1'b1, 1'b1, 1'b1, 1'b1, 1'b0), "CSRA");

      // Fault arriving during a completion acknowledge waits its turn
      pulseEvent(1'b1, 1'b0, 4'd0);
      expectRequest(1'b1, vecDone);
      @(negedge clk);
      iack         = 1'b1;
      printerFault = 1'b1;
      faultCode    = code;
      @(negedge clk);
      printerFault = 1'b0;
      // Grant stays on completion while iack holds
      expectRequest(1'b1, vecDone);
      @(negedge clk);
      iack = 1'b0;
      @(posedge clk);
      expectRequest(1'b1, vecErr);
      randWord = $random(seed);
      holdLen  = 1 + randWord[1:0];
      acknowledge(holdLen, vecErr);
      expectRequest(1'b0, 8'h00);
      readCheck(addrCsra, csraImage(1'b1, 1'b1, 1'b1, 1'b1, 1'b0), "CSRA");

      // No retrigger before the status read
      apbWrite(addrCsra, 16'd1 << bitDoneIe);
      pulseEvent(1'b1, 1'b0, 4'd0);
      expectRequest(1'b1, vecDone);
      randWord = $random(seed);
      holdLen  = 1 + randWord[1:0];
      acknowledge(holdLen, vecDone);
      expectRequest(1'b0, 8'h00);
      pulseEvent(1'b1, 1'b0, 4'd0);
      expectRequest(1'b0, 8'h00);
      expectRequest(1'b0, 8'h00);
      readCheck(addrCsra, csraImage(1'b1, 1'b0, 1'b1, 1'b0, 1'b0), "CSRA");
      pulseEvent(1'b1, 1'b0, 4'd0);
      expectRequest(1'b1, vecDone);

      // Init with the completion request pending
      randWord = $random(seed);
      code     = randWord[3:0];
      pulseEvent(1'b0, 1'b1, code);
      apbWrite(addrCsra, (16'd1 << bitGo) | (16'd1 << bitDoneIe));
      readCheck(addrCsrb, {12'd0, code}, "CSRB");
      expectRequest(1'b1, vecDone);
      apbWrite(addrCsra, (16'd1 << bitInit) | (16'd1 << bitDoneIe));
      expectRequest(1'b0, 8'h00);
      readCheck(addrCsra, csraImage(1'b1, 1'b0, 1'b0, 1'b0, 1'b0), "CSRA");
      readCheck(addrCsrb, 16'h0000, "CSRB");
      expectRequest(1'b0, 8'h00);

      $display("Run complete after %0d cycles with %0d errors", cycleCount, errorCount);
      if (errorCount == 0)
      begin
         $display("TESTS PASSED");
      end
      else
      begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- project.f
source/lpPkg.sv
source/lpIntr.sv
source/lpCsr.sv
source/lpIntArb.sv
source/lpTop.sv
tb/lpTb.sv
